// ==== tests/atom_exec_testdata.txt ====
# W addr data: host register write, all fields hex
# I func rd rs1 rs2 use_imm imm expected zero: issue with expected result, all fields hex
W 01 80000000
W 02 ffffffff
W 03 00000001
W 04 0000001f
W 05 12345678
W 06 12345678
W 07 0f0f0f0f
W 00 deadbeef
I 0 0a 01 02 0 00000000 7fffffff 0
I 0 0b 02 03 0 00000000 00000000 1
I 0 0c 01 01 0 00000000 00000000 1
I 1 0d 05 06 0 00000000 00000000 1
I 1 0e 00 03 0 00000000 ffffffff 0
I 1 0f 01 02 1 00000001 7fffffff 0
I 2 10 02 07 0 00000000 f0f0f0f0 0
I 2 11 05 06 0 00000000 00000000 1
I 3 12 01 03 0 00000000 80000001 0
I 3 13 00 00 0 00000000 00000000 1
I 4 14 02 07 0 00000000 0f0f0f0f 0
I 4 15 05 02 1 00000000 00000000 1
I 5 16 03 00 1 00000000 00000001 0
I 5 17 03 04 0 00000000 80000000 0
I 5 18 02 00 1 00000004 fffffff0 0
I 5 19 05 00 1 00000024 23456780 0
I 6 1a 01 04 0 00000000 00000001 0
I 6 1b 02 00 1 00000000 ffffffff 0
I 6 1c 01 00 1 00000004 08000000 0
I 7 1d 01 04 0 00000000 ffffffff 0
I 7 1e 01 00 1 00000004 f8000000 0
I 7 1f 05 00 1 00000004 01234567 0
I 0 01 00 02 1 00000010 00000010 0
W 03 00000005
I 0 02 03 00 1 00000000 00000005 0

// ==== tb.f ====
hdl/atom_exec_pkg.sv
hdl/exec_if.sv
hdl/operand_fetch.sv
hdl/op_delay_pipe.sv
hdl/alu.sv
hdl/execute_unit.sv
hdl/atom_exec_top.sv
tests/tb_atom_exec.sv

// ==== Makefile ====
# Verilator flow for the execute slice
TOP := tb_atom_exec
LOG := sim.log

.PHONY: all lint sim clean

all: sim

# RTL top on its own, then the full testbench build
lint:
	verilator --lint-only $(filter hdl/%,$(shell cat tb.f)) --top-module atom_exec_top
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

# Pass or fail comes from the log, not the exit code of the pipe
sim:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_atom_exec.sv ====
// Testbench for the execute slice with file driven, directed and seeded random operations
module tb_atom_exec;

    import atom_exec_pkg::*;

    localparam int unsigned PIPE_DEPTH = 2;
    localparam int unsigned LATENCY    = PIPE_DEPTH + 2;
    localparam int unsigned NUM_RANDOM = 200;

    // Expected result plus the edge that sampled its issue
    typedef struct packed {
        word_t       res;
        reg_addr_t   rd;
        logic        zero;
        logic [31:0] stamp;
    } exp_t;

    // One data file record, write or issue
    typedef struct packed {
        logic      is_write;
        reg_addr_t addr;
        word_t     data;
        alu_func_e func;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        word_t     imm;
        word_t     res;
        logic      zero;
    } rec_t;

    logic      clk_i;
    logic      rst_n_i;
    logic      reg_we_i;
    reg_addr_t reg_waddr_i;
    word_t     reg_wdata_i;
    logic      issue_i;
    alu_func_e func_i;
    reg_addr_t rd_i;
    reg_addr_t rs1_i;
    reg_addr_t rs2_i;
    logic      use_imm_i;
    word_t     imm_i;
    logic      result_valid_o;
    reg_addr_t result_rd_o;
    word_t     result_o;
    logic      result_zero_o;

    exp_t        exp_q[$];
    rec_t        recs[$];
    // Host view of the register file
    word_t       shadow [32];
    int          seed = 32'h158ef738;
    int unsigned cycle_cnt;
    int unsigned cycle_limit = 100;

    atom_exec_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .reg_we_i       (reg_we_i),
        .reg_waddr_i    (reg_waddr_i),
        .reg_wdata_i    (reg_wdata_i),
        .issue_i        (issue_i),
        .func_i         (func_i),
        .rd_i           (rd_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .use_imm_i      (use_imm_i),
        .imm_i          (imm_i),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o),
        .result_zero_o  (result_zero_o)
    );

    always #4 clk_i = ~clk_i;

    //////////////////////////////
    // Reporting and compares
    //////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    // Result word and its destination tag
    task automatic check_word(input word_t got, input word_t exp, input reg_addr_t got_rd,
                              input reg_addr_t exp_rd);
        if (got !== exp || got_rd !== exp_rd) begin
            fail_run($sformatf("Mismatch at time %0t: result %h tag %0d, expected %h tag %0d",
                               $time, got, got_rd, exp, exp_rd));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at time %0t: zero flag %b, expected %b",
                               $time, got, exp));
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic word_t read_shadow(input reg_addr_t addr);
        return (addr == '0) ? '0 : shadow[addr];
    endfunction

    // Straight from the ALU rules, shift amount is b[4:0]
    function automatic word_t model_alu(input alu_func_e f, input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_XOR: return a ^ b;
            ALU_OR:  return a | b;
            ALU_AND: return a & b;
            ALU_SLL: return a << sh;
            ALU_SRL: return a >> sh;
            ALU_SRA: return word_t'($signed(a) >>> sh);
            default: return '0;
        endcase
    endfunction

    //////////////////////////////
    // Drivers, called at negedge
    //////////////////////////////

    task automatic drive_idle();
        reg_we_i = 1'b0;
        issue_i  = 1'b0;
    endtask

    // Shadow updated after any same cycle issue has read it
    task automatic drive_write(input reg_addr_t addr, input word_t data);
        reg_we_i    = 1'b1;
        reg_waddr_i = addr;
        reg_wdata_i = data;
        if (addr != '0) begin
            shadow[addr] = data;
        end
    endtask

    task automatic issue_expected(input alu_func_e func, input reg_addr_t rd,
                                  input reg_addr_t rs1, input reg_addr_t rs2,
                                  input logic use_imm, input word_t imm,
                                  input word_t res, input logic zero);
        exp_t e;
        issue_i   = 1'b1;
        func_i    = func;
        rd_i      = rd;
        rs1_i     = rs1;
        rs2_i     = rs2;
        use_imm_i = use_imm;
        imm_i     = imm;
        e.res     = res;
        e.rd      = rd;
        e.zero    = zero;
        // Sampling edge is the next posedge
        e.stamp   = cycle_cnt + 1;
        exp_q.push_back(e);
    endtask

    task automatic issue_modeled(input alu_func_e func, input reg_addr_t rd,
                                 input reg_addr_t rs1, input reg_addr_t rs2,
                                 input logic use_imm, input word_t imm);
        word_t b;
        word_t res;
        b   = use_imm ? imm : read_shadow(rs2);
        res = model_alu(func, read_shadow(rs1), b);
        issue_expected(func, rd, rs1, rs2, use_imm, imm, res, res == '0);
    endtask

    //////////////////////////////
    // Stimulus phases
    //////////////////////////////

    task automatic read_testdata();
        int            fd;
        int            code;
        logic [7:0]    kind;
        logic [1023:0] line_buf;
        logic [31:0]   f [8];
        rec_t          rec;
        fd = $fopen("tests/atom_exec_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the data file tests/atom_exec_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) break;
                rec = '0;
                if (kind == "#") begin
                    code = $fgets(line_buf, fd);
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    rec.is_write = 1'b1;
                    rec.addr     = reg_addr_t'(f[0]);
                    rec.data     = f[1];
                    recs.push_back(rec);
                end else if (kind == "I") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    rec.func    = alu_func_e'(f[0][2:0]);
                    rec.rd      = reg_addr_t'(f[1]);
                    rec.rs1     = reg_addr_t'(f[2]);
                    rec.rs2     = reg_addr_t'(f[3]);
                    rec.use_imm = f[4][0];
                    rec.imm     = f[5];
                    rec.res     = f[6];
                    rec.zero    = f[7][0];
                    recs.push_back(rec);
                end else begin
                    fail_run($sformatf("Unknown record kind %c in the data file", kind));
                end
            end
            $fclose(fd);
        end
    endtask

    // One record per cycle, so consecutive issues go back to back
    task automatic play_records();
        foreach (recs[i]) begin
            @(negedge clk_i);
            drive_idle();
            if (recs[i].is_write) begin
                drive_write(recs[i].addr, recs[i].data);
            end else begin
                issue_expected(recs[i].func, recs[i].rd, recs[i].rs1, recs[i].rs2,
                               recs[i].use_imm, recs[i].imm, recs[i].res, recs[i].zero);
            end
        end
    endtask

    // Issue reading x5 in the write cycle sees the old value, next cycle the new one
    task automatic same_cycle_write();
        @(negedge clk_i);
        drive_idle();
        issue_modeled(ALU_ADD, 5'd20, 5'd5, 5'd0, 1'b0, '0);
        drive_write(5'd5, 32'hcafe_f00d);
        @(negedge clk_i);
        drive_idle();
        issue_modeled(ALU_XOR, 5'd21, 5'd5, 5'd0, 1'b1, 32'hcafe_f00d);
    endtask

    // Edge values are favoured over plain random words
    task automatic pick_operand(output word_t val);
        int r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    val = '0;
            3'd1:    val = 32'h8000_0000;
            3'd2:    val = '1;
            3'd3:    val = 32'h0000_001f;
            default: val = $random(seed);
        endcase
    endtask

    task automatic random_ops();
        int          r;
        int unsigned done;
        word_t       imm;
        word_t       wdata;
        done = 0;
        while (done < NUM_RANDOM) begin
            @(negedge clk_i);
            drive_idle();
            r = $random(seed);
            // Issue in three cycles of four, write in every other
            if (r[1:0] != 2'b00) begin
                pick_operand(imm);
                issue_modeled(alu_func_e'(r[4:2]), r[9:5], r[14:10], r[19:15], r[20], imm);
                done = done + 1;
            end
            if (r[21]) begin
                pick_operand(wdata);
                drive_write(r[26:22], wdata);
            end
        end
    endtask

    //////////////////////////////
    // Monitor and watchdog
    //////////////////////////////

    always @(negedge clk_i) begin
        exp_t e;
        if (result_valid_o) begin
            if (exp_q.size() == 0) begin
                fail_run("A result appeared while no operation was outstanding");
            end else begin
                e = exp_q.pop_front();
                if (cycle_cnt - e.stamp != LATENCY) begin
                    fail_run($sformatf("Mismatch at time %0t: latency %0d, expected %0d",
                                       $time, cycle_cnt - e.stamp, LATENCY));
                end
                check_word(result_o, e.res, result_rd_o, e.rd);
                check_flag(result_zero_o, e.zero);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles with results still missing", cycle_cnt));
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        reg_we_i    = 1'b0;
        reg_waddr_i = '0;
        reg_wdata_i = '0;
        issue_i     = 1'b0;
        func_i      = ALU_ADD;
        rd_i        = '0;
        rs1_i       = '0;
        rs2_i       = '0;
        use_imm_i   = 1'b0;
        imm_i       = '0;
        cycle_cnt   = 0;
        // Reset clears the register file
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        read_testdata();
        cycle_limit = 4 * (recs.size() + NUM_RANDOM) + 100;
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        // Quiet stretch, monitor flags any stray result
        repeat (LATENCY + 2) @(negedge clk_i);
        play_records();
        same_cycle_write();
        random_ops();
        @(negedge clk_i);
        drive_idle();
        // Last result is due LATENCY cycles after its issue
        repeat (LATENCY + 2) @(negedge clk_i);
        if (exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_run("Results were still outstanding at the end of the run");
        end
    end

endmodule

// ==== hdl/atom_exec_top.sv ====
// Execute slice top level joining fetch, delay pipe and execute stages
module atom_exec_top #(
    parameter int unsigned PIPE_DEPTH = atom_exec_pkg::PIPE_DEPTH_DEF
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Host register write
    input  logic                     reg_we_i,
    input  atom_exec_pkg::reg_addr_t reg_waddr_i,
    input  atom_exec_pkg::word_t     reg_wdata_i,

    // Operation issue
    input  logic                     issue_i,
    input  atom_exec_pkg::alu_func_e func_i,
    input  atom_exec_pkg::reg_addr_t rd_i,
    input  atom_exec_pkg::reg_addr_t rs1_i,
    input  atom_exec_pkg::reg_addr_t rs2_i,
    input  logic                     use_imm_i,
    input  atom_exec_pkg::word_t     imm_i,

    // Results, PIPE_DEPTH+2 cycles after issue
    output logic                     result_valid_o,
    output atom_exec_pkg::reg_addr_t result_rd_o,
    output atom_exec_pkg::word_t     result_o,
    output logic                     result_zero_o
);

    //////////////////////////////
    // Stage links
    //////////////////////////////

    exec_if fetch_to_pipe ();
    exec_if pipe_to_exec ();

    // Register read and operand select, 1 cycle
    operand_fetch u_operand_fetch (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .reg_we_i    (reg_we_i),
        .reg_waddr_i (reg_waddr_i),
        .reg_wdata_i (reg_wdata_i),
        .issue_i     (issue_i),
        .func_i      (func_i),
        .rd_i        (rd_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .use_imm_i   (use_imm_i),
        .imm_i       (imm_i),
        .out_o       (fetch_to_pipe.src)
    );

    // Balancing delay, PIPE_DEPTH cycles
    op_delay_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_op_delay_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .in_i    (fetch_to_pipe.dst),
        .out_o   (pipe_to_exec.src)
    );

    // ALU and result register, 1 cycle
    execute_unit u_execute_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .op_i           (pipe_to_exec.dst),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o),
        .result_zero_o  (result_zero_o)
    );

endmodule

// ==== hdl/execute_unit.sv ====
// Execute stage with ALU and registered result, tag and zero flag
module execute_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Operation delivered by the delay pipe
    exec_if.dst                      op_i,

    // Result port
    output logic                     result_valid_o,
    output atom_exec_pkg::reg_addr_t result_rd_o,
    output atom_exec_pkg::word_t     result_o,
    output logic                     result_zero_o
);

    import atom_exec_pkg::*;

    // Combinational ALU output
    word_t alu_res;

    alu u_alu (
        .a_i      (op_i.a),
        .b_i      (op_i.b),
        .func_i   (op_i.func),
        .result_o (alu_res)
    );

    // Zero detect before the output register
    logic alu_zero;
    assign alu_zero = (alu_res == '0);

    //////////////////////////////
    // Output registers
    //////////////////////////////

    // One pulse per delivered operation
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= op_i.valid;
        end
    end

    // Result fields hold until the next operation
    always_ff @(posedge clk_i) begin
        if (op_i.valid) begin
            result_o      <= alu_res;
            result_rd_o   <= op_i.rd;
            result_zero_o <= alu_zero;
        end
    end

endmodule

// ==== hdl/alu.sv ====
// Eight function integer ALU with shared adder and one universal shifter
module alu (
    input  atom_exec_pkg::word_t     a_i,
    input  atom_exec_pkg::word_t     b_i,
    input  atom_exec_pkg::alu_func_e func_i,

    output atom_exec_pkg::word_t     result_o
);

    import atom_exec_pkg::*;

    //////////////////////////////
    // Function decode
    //////////////////////////////

    logic sel_add;
    logic sel_sub;
    logic sel_xor;
    logic sel_or;
    logic sel_sll;
    logic sel_srl;
    logic sel_sra;

    // One-hot selects, AND is the fall-through case
    assign sel_add = (func_i == ALU_ADD);
    assign sel_sub = (func_i == ALU_SUB);
    assign sel_xor = (func_i == ALU_XOR);
    assign sel_or  = (func_i == ALU_OR);
    assign sel_sll = (func_i == ALU_SLL);
    assign sel_srl = (func_i == ALU_SRL);
    assign sel_sra = (func_i == ALU_SRA);

    //////////////////////////////
    // Adder
    //////////////////////////////

    // Sub as a plus inverted b plus carry in
    word_t arith_res;
    assign arith_res = a_i + (sel_sub ? ~b_i : b_i) + word_t'(sel_sub);

    //////////////////////////////
    // Universal shifter
    //////////////////////////////

    // Mirror a word end for end
    function automatic word_t bit_rev(input word_t val);
        word_t rev;
        for (int i = 0; i < XLEN; i++) begin
            rev[XLEN-1-i] = val[i];
        end
        return rev;
    endfunction

    // Extra top bit carries the fill value
    logic signed [XLEN:0] shift_in;
    word_t                shift_raw;
    word_t                shift_res;

    always_comb begin
        if (sel_sra) begin
            shift_in = {a_i[XLEN-1], a_i};
        end else if (sel_srl) begin
            shift_in = {1'b0, a_i};
        end else begin
            // sll goes through the right shifter mirrored
            shift_in = {1'b0, bit_rev(a_i)};
        end
    end

    // Only the low five bits of b count
    assign shift_raw = word_t'(shift_in >>> b_i[4:0]);

    // Undo the mirror for sll
    assign shift_res = sel_sll ? bit_rev(shift_raw) : shift_raw;

    //////////////////////////////
    // Result select
    //////////////////////////////

    always_comb begin
        if (sel_add || sel_sub) begin
            result_o = arith_res;
        end else if (sel_sll || sel_srl || sel_sra) begin
            result_o = shift_res;
        end else if (sel_xor) begin
            result_o = a_i ^ b_i;
        end else if (sel_or) begin
            result_o = a_i | b_i;
        end else begin
            result_o = a_i & b_i;
        end
    end

endmodule

// ==== hdl/op_delay_pipe.sv ====
// Fixed latency register chain between operand fetch and execute
module op_delay_pipe #(
    parameter int unsigned PIPE_DEPTH = atom_exec_pkg::PIPE_DEPTH_DEF
) (
    input  logic   clk_i,
    input  logic   rst_n_i,

    // Operations from fetch
    exec_if.dst    in_i,

    // Operations towards execute
    exec_if.src    out_o
);

    import atom_exec_pkg::*;

    // Per stage state, index 0 nearest the input
    logic      valid_q [PIPE_DEPTH];
    alu_func_e func_q  [PIPE_DEPTH];
    word_t     a_q     [PIPE_DEPTH];
    word_t     b_q     [PIPE_DEPTH];
    reg_addr_t rd_q    [PIPE_DEPTH];

    for (genvar g = 0; g < PIPE_DEPTH; g++) begin : g_stage
        logic      src_valid;
        alu_func_e src_func;
        word_t     src_a;
        word_t     src_b;
        reg_addr_t src_rd;

        // First stage takes the interface, the rest take the previous stage
        if (g == 0) begin : g_head
            assign src_valid = in_i.valid;
            assign src_func  = in_i.func;
            assign src_a     = in_i.a;
            assign src_b     = in_i.b;
            assign src_rd    = in_i.rd;
        end else begin : g_link
            assign src_valid = valid_q[g-1];
            assign src_func  = func_q[g-1];
            assign src_a     = a_q[g-1];
            assign src_b     = b_q[g-1];
            assign src_rd    = rd_q[g-1];
        end

        // Valid bit, cleared by reset
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                valid_q[g] <= 1'b0;
            end else begin
                valid_q[g] <= src_valid;
            end
        end

        // Payload moves only with a live operation
        always_ff @(posedge clk_i) begin
            if (src_valid) begin
                func_q[g] <= src_func;
                a_q[g]    <= src_a;
                b_q[g]    <= src_b;
                rd_q[g]   <= src_rd;
            end
        end
    end

    // Last stage drives execute
    assign out_o.valid = valid_q[PIPE_DEPTH-1];
    assign out_o.func  = func_q[PIPE_DEPTH-1];
    assign out_o.a     = a_q[PIPE_DEPTH-1];
    assign out_o.b     = b_q[PIPE_DEPTH-1];
    assign out_o.rd    = rd_q[PIPE_DEPTH-1];

endmodule

// ==== hdl/operand_fetch.sv ====
// Operand fetch with host loaded register file and immediate select
module operand_fetch (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Host write port
    input  logic                    reg_we_i,
    input  atom_exec_pkg::reg_addr_t reg_waddr_i,
    input  atom_exec_pkg::word_t    reg_wdata_i,

    // Issue port
    input  logic                    issue_i,
    input  atom_exec_pkg::alu_func_e func_i,
    input  atom_exec_pkg::reg_addr_t rd_i,
    input  atom_exec_pkg::reg_addr_t rs1_i,
    input  atom_exec_pkg::reg_addr_t rs2_i,
    input  logic                    use_imm_i,
    input  atom_exec_pkg::word_t    imm_i,

    // Fetched operation towards the delay pipe
    exec_if.src                     out_o
);

    import atom_exec_pkg::*;

    // Number of architectural registers
    localparam int unsigned NUM_REGS = 2 ** REG_AW;

    //////////////////////////////
    // Register file
    //////////////////////////////

    // x0 has no storage, reads are forced to zero below
    word_t regs_q [1:NUM_REGS-1];

    // Host writes, x0 writes dropped
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (reg_we_i && (reg_waddr_i != '0)) begin
            regs_q[reg_waddr_i] <= reg_wdata_i;
        end
    end

    //////////////////////////////
    // Operand read
    //////////////////////////////

    // Combinational read of the current contents
    // A write at the same edge lands after these are sampled
    word_t rs1_val;
    word_t rs2_val;
    word_t b_sel;

    assign rs1_val = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_val = (rs2_i == '0) ? '0 : regs_q[rs2_i];

    // Immediate replaces rs2
    assign b_sel = use_imm_i ? imm_i : rs2_val;

    //////////////////////////////
    // Issue registers
    //////////////////////////////

    // Capture stage, loaded at the sampling edge
    logic      issue_q;
    alu_func_e func_q;
    word_t     a_q;
    word_t     b_q;
    reg_addr_t rd_q;

    // Valid strobe, one cycle after the sampling edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_q     <= 1'b0;
            out_o.valid <= 1'b0;
        end else begin
            issue_q     <= issue_i;
            out_o.valid <= issue_q;
        end
    end

    // Operands read before a same edge write lands
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            func_q <= func_i;
            a_q    <= rs1_val;
            b_q    <= b_sel;
            rd_q   <= rd_i;
        end
    end

    // Payload held between issues
    always_ff @(posedge clk_i) begin
        if (issue_q) begin
            out_o.func <= func_q;
            out_o.a    <= a_q;
            out_o.b    <= b_q;
            out_o.rd   <= rd_q;
        end
    end

endmodule

// ==== hdl/exec_if.sv ====
// Issued operation bundle with producer and consumer modports
interface exec_if;

    import atom_exec_pkg::*;

    // Single cycle strobe, one per operation
    logic      valid;

    // Payload, meaningful only with valid high
    alu_func_e func;
    // Operand a, always rs1
    word_t     a;
    // Operand b, rs2 or immediate
    word_t     b;
    // Destination tag
    reg_addr_t rd;

    // Producer side
    modport src (
        output valid,
        output func,
        output a,
        output b,
        output rd
    );

    // Consumer side
    modport dst (
        input  valid,
        input  func,
        input  a,
        input  b,
        input  rd
    );

endinterface

// ==== hdl/atom_exec_pkg.sv ====
// Data word and register address types, ALU function codes, delay pipeline default depth
package atom_exec_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Data path width of the core
    localparam int unsigned XLEN = 32;

    // Register address width, 32 architectural registers
    localparam int unsigned REG_AW = 5;

    //////////////////////////////
    // Types
    //////////////////////////////

    // One data word
    typedef logic [XLEN-1:0] word_t;

    // One register address or destination tag
    typedef logic [REG_AW-1:0] reg_addr_t;

    // ALU function select
    // Code order matches the host issue encoding
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_XOR = 3'd2,
        ALU_OR  = 3'd3,
        ALU_AND = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SRA = 3'd7
    } alu_func_e;

    //////////////////////////////
    // Pipeline
    //////////////////////////////

    // Default delay stages between operand fetch and execute
    // Any value of 1 or more is legal
    localparam int unsigned PIPE_DEPTH_DEF = 2;

endpackage
